/* verilog/writeback_macros.svh */
`ifndef WRITEBACK_MACROS_SVH
`define WRITEBACK_MACROS_SVH

// result slots per functional unit kind
`define NUM_FU_ALU 3
`define NUM_FU_MULT 2
`define NUM_FU_LOAD 2
`define NUM_FU (`NUM_FU_ALU + `NUM_FU_MULT + `NUM_FU_LOAD)

// bus lanes broadcast per cycle
`define CDB_WIDTH 2

// field widths
`define PRN_WIDTH 6
`define ROB_WIDTH 5
`define DATA_WIDTH 32

`endif

/* verilog/writeback_pkg.sv */
`include "writeback_macros.svh"

package writeback_pkg;

    // finished result handed over by a functional unit
    typedef struct packed {
        logic [`ROB_WIDTH-1:0]  robn;
        logic [`PRN_WIDTH-1:0]  dest_prn;
        logic [`DATA_WIDTH-1:0] value;
    } fu_result_t;

    // one common data bus lane
    typedef struct packed {
        logic                   valid;
        logic [`PRN_WIDTH-1:0]  dest_prn;
        logic [`DATA_WIDTH-1:0] value;
    } cdb_packet_t;

    // completion notice to the reorder buffer
    typedef struct packed {
        logic                  valid;
        logic [`ROB_WIDTH-1:0] robn;
    } rob_complete_t;

    // destination register handed out by rename
    typedef struct packed {
        logic                  valid;
        logic [`PRN_WIDTH-1:0] prn;
    } prn_alloc_t;

endpackage

/* verilog/psel_gen.sv */
`timescale 1ns/1ps

module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]           req,
    output logic [WIDTH-1:0]           gnt,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
    output logic                       empty
);

    // requests not yet granted by an earlier row
    logic [WIDTH-1:0] remaining;

    // each row takes the lowest-index request still open
    always_comb begin
        logic found;
        remaining = req;
        gnt_bus = '0;
        for (int r = 0; r < REQS; r++) begin
            found = 1'b0;
            for (int i = 0; i < WIDTH; i++) begin
                if (remaining[i] && !found) begin
                    gnt_bus[r][i] = 1'b1;
                    remaining[i] = 1'b0;
                    found = 1'b1;
                end
            end
        end
    end

    // combined grant is the OR of all rows
    always_comb begin
        gnt = '0;
        for (int r = 0; r < REQS; r++) begin
            gnt = gnt | gnt_bus[r];
        end
    end

    assign empty = ~|req;

endmodule

/* verilog/cdb_lane_mux.sv */
`timescale 1ns/1ps

module cdb_lane_mux #(
    parameter int WIDTH = 8,
    parameter int SIZE  = 32
) (
    input  logic [WIDTH-1:0][SIZE-1:0] in,
    input  logic [WIDTH-1:0]           select,
    output logic [SIZE-1:0]            out
);

    // and-or over the one-hot select
    // an empty select leaves the lane at zero
    always_comb begin
        out = '0;
        for (int i = 0; i < WIDTH; i++) begin
            out = out | (in[i] & {SIZE{select[i]}});
        end
    end

endmodule

/* verilog/cdb.sv */
`include "writeback_macros.svh"
`timescale 1ns/1ps

module cdb
    import writeback_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    input  logic [`NUM_FU-1:0]              fu_valid,
    output logic [`NUM_FU-1:0]              fu_ready,
    input  fu_result_t [`NUM_FU-1:0]        fu_result,
    output cdb_packet_t [`CDB_WIDTH-1:0]    cdb_out,
    output rob_complete_t [`CDB_WIDTH-1:0]  rob_out
);

    // per-slot holding registers
    fu_result_t [`NUM_FU-1:0] held_result;
    logic [`NUM_FU-1:0]       held;

    // arbitration results
    logic [`NUM_FU-1:0]                  granted;
    logic [`CDB_WIDTH-1:0][`NUM_FU-1:0]  grant_rows;
    logic [`NUM_FU-1:0]                  accept;

    // lane contents before packing
    fu_result_t [`CDB_WIDTH-1:0] lane_result;
    logic [`CDB_WIDTH-1:0]       lane_valid;

    // slot can take a new result if empty or leaving this cycle
    assign fu_ready = granted | ~held;
    assign accept   = fu_valid & fu_ready;

    // slot 0 first, up to CDB_WIDTH grants
    psel_gen #(
        .WIDTH(`NUM_FU),
        .REQS (`CDB_WIDTH)
    ) slot_sel (
        .req    (held),
        .gnt    (granted),
        .gnt_bus(grant_rows),
        .empty  ()
    );

    genvar l;
    generate
        for (l = 0; l < `CDB_WIDTH; l++) begin : g_lane
            cdb_lane_mux #(
                .WIDTH(`NUM_FU),
                .SIZE ($bits(fu_result_t))
            ) result_mux (
                .in    (held_result),
                .select(grant_rows[l]),
                .out   (lane_result[l])
            );

            cdb_lane_mux #(
                .WIDTH(`NUM_FU),
                .SIZE (1)
            ) valid_mux (
                .in    (held),
                .select(grant_rows[l]),
                .out   (lane_valid[l])
            );

            // same lane feeds the bus and the rob notice
            assign cdb_out[l] = '{
                valid:    lane_valid[l],
                dest_prn: lane_result[l].dest_prn,
                value:    lane_result[l].value
            };
            assign rob_out[l] = '{
                valid: lane_valid[l],
                robn:  lane_result[l].robn
            };
        end
    endgenerate

    // granted slots drop out unless refilled at the same edge
    always_ff @(posedge clock) begin
        if (reset) begin
            held <= '0;
        end else begin
            held <= (held & ~granted) | accept;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `NUM_FU; i++) begin
            if (accept[i]) begin
                held_result[i] <= fu_result[i];
            end
        end
    end

endmodule

/* verilog/prf_ready_table.sv */
`include "writeback_macros.svh"
`timescale 1ns/1ps

module prf_ready_table
    import writeback_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    input  prn_alloc_t [`CDB_WIDTH-1:0]        alloc,
    input  cdb_packet_t [`CDB_WIDTH-1:0]       cdb_in,
    input  logic [1:0][`PRN_WIDTH-1:0]         query_prn,
    output logic [1:0]                         query_ready
);

    localparam int NUM_PRN = 1 << `PRN_WIDTH;

    logic [NUM_PRN-1:0] ready_bits;
    logic [NUM_PRN-1:0] next_ready;

    // clear on allocation, then set on broadcast so a same-cycle set wins
    always_comb begin
        next_ready = ready_bits;
        for (int a = 0; a < `CDB_WIDTH; a++) begin
            if (alloc[a].valid) begin
                next_ready[alloc[a].prn] = 1'b0;
            end
        end
        for (int c = 0; c < `CDB_WIDTH; c++) begin
            if (cdb_in[c].valid) begin
                next_ready[cdb_in[c].dest_prn] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ready_bits <= '1;
        end else begin
            ready_bits <= next_ready;
        end
    end

    // lookup from the registered table only
    always_comb begin
        for (int q = 0; q < 2; q++) begin
            query_ready[q] = ready_bits[query_prn[q]];
        end
    end

endmodule

/* verilog/writeback_stage.sv */
`include "writeback_macros.svh"
`timescale 1ns/1ps

module writeback_stage
    import writeback_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    input  logic [`NUM_FU-1:0]              fu_valid,
    output logic [`NUM_FU-1:0]              fu_ready,
    input  fu_result_t [`NUM_FU-1:0]        fu_result,
    output cdb_packet_t [`CDB_WIDTH-1:0]    cdb_out,
    output rob_complete_t [`CDB_WIDTH-1:0]  rob_out,
    input  prn_alloc_t [`CDB_WIDTH-1:0]     alloc,
    input  logic [1:0][`PRN_WIDTH-1:0]      query_prn,
    output logic [1:0]                      query_ready
);

    // bus arbiter and result holding
    cdb cdb_unit (
        .clock    (clock),
        .reset    (reset),
        .fu_valid (fu_valid),
        .fu_ready (fu_ready),
        .fu_result(fu_result),
        .cdb_out  (cdb_out),
        .rob_out  (rob_out)
    );

    // snoops the bus lanes directly
    prf_ready_table ready_table (
        .clock      (clock),
        .reset      (reset),
        .alloc      (alloc),
        .cdb_in     (cdb_out),
        .query_prn  (query_prn),
        .query_ready(query_ready)
    );

endmodule

/* verification/writeback_assertions.sv */
`include "writeback_macros.svh"
`timescale 1ns/1ps

module writeback_assertions
    import writeback_pkg::*;
(
    input logic                            clock,
    input logic                            reset,
    input logic [`NUM_FU-1:0]              held,
    input logic [`NUM_FU-1:0]              fu_ready,
    input fu_result_t [`NUM_FU-1:0]        held_result,
    input cdb_packet_t [`CDB_WIDTH-1:0]    cdb_out,
    input rob_complete_t [`CDB_WIDTH-1:0]  rob_out
);

    unique_rob: assert property (@(posedge clock) disable iff (reset)
        (rob_out[0].valid && rob_out[1].valid) |-> (rob_out[0].robn != rob_out[1].robn))
        else $error("both lanes carry the same rob index");

    lane_order: assert property (@(posedge clock) disable iff (reset)
        !cdb_out[0].valid |-> !cdb_out[1].valid)
        else $error("lane 1 valid while lane 0 is idle");

    // a blocked slot must not lose or change its result
    genvar i;
    generate
        for (i = 0; i < `NUM_FU; i++) begin : g_hold
            hold_stable: assert property (@(posedge clock) disable iff (reset)
                (held[i] && !fu_ready[i]) |=> $stable(held_result[i]))
                else $error("held result changed while slot not ready");
        end
    endgenerate

endmodule

bind cdb writeback_assertions hold_checks (
    .clock      (clock),
    .reset      (reset),
    .held       (held),
    .fu_ready   (fu_ready),
    .held_result(held_result),
    .cdb_out    (cdb_out),
    .rob_out    (rob_out)
);

/* verification/writeback_checker.sv */
`include "writeback_macros.svh"
`timescale 1ns/1ps

module writeback_checker
    import writeback_pkg::*;
(
    input  logic                            clock,
    input  logic [`NUM_FU-1:0]              fu_ready,
    input  cdb_packet_t [`CDB_WIDTH-1:0]    cdb_out,
    input  rob_complete_t [`CDB_WIDTH-1:0]  rob_out,
    input  logic [1:0]                      query_ready,
    input  logic                            case_go,
    input  logic [21:0][31:0]               case_words,
    input  logic                            all_done,
    output int                              cases_checked,
    output int                              error_count
);

    localparam int TIMEOUT = 20;

    int case_errors;
    int pass_count;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL case %0d %s got %h expected %h", case_words[0], name, got, exp);
            case_errors++;
        end
    endtask

    // slot broadcast as the k-th result of the case
    function automatic int order_slot(input int k);
        int count;
        count = int'(case_words[19]);
        return int'(case_words[18][4*(count-1-k) +: 4]);
    endfunction

    task automatic check_lane(input int l, input int slot);
        compare($sformatf("cdb_out[%0d].valid", l), 32'(cdb_out[l].valid), 32'h1);
        compare($sformatf("rob_out[%0d].valid", l), 32'(rob_out[l].valid), 32'h1);
        compare($sformatf("cdb_out[%0d].dest_prn", l), 32'(cdb_out[l].dest_prn),
                32'(case_words[2+slot][5:0]));
        compare($sformatf("cdb_out[%0d].value", l), cdb_out[l].value, case_words[9+slot]);
        compare($sformatf("rob_out[%0d].robn", l), 32'(rob_out[l].robn),
                32'(case_words[2+slot][12:8]));
    endtask

    task automatic check_case();
        int count;
        int idx;
        int t;
        logic timed_out;
        logic [`NUM_FU-1:0] exp_ready;
        count = int'(case_words[19]);
        idx = 0;
        timed_out = 1'b0;
        case_errors = 0;
        // nothing held before the case starts
        compare("fu_ready", 32'(fu_ready), 32'(7'h7f));
        compare("cdb_out[0].valid", 32'(cdb_out[0].valid), 32'h0);
        compare("cdb_out[1].valid", 32'(cdb_out[1].valid), 32'h0);
        while (idx < count && !timed_out) begin
            t = 0;
            while (!cdb_out[0].valid && t < TIMEOUT) begin
                @(negedge clock);
                t++;
            end
            if (!cdb_out[0].valid) begin
                $display("case %0d: no broadcast arrived within %0d cycles",
                         case_words[0], TIMEOUT);
                case_errors++;
                timed_out = 1'b1;
            end else begin
                check_lane(0, order_slot(idx));
                if (idx + 1 < count) begin
                    check_lane(1, order_slot(idx + 1));
                end else begin
                    // an unused lane carries all-zero fields
                    compare("cdb_out[1].valid", 32'(cdb_out[1].valid), 32'h0);
                    compare("cdb_out[1].dest_prn", 32'(cdb_out[1].dest_prn), 32'h0);
                    compare("cdb_out[1].value", cdb_out[1].value, 32'h0);
                    compare("rob_out[1].valid", 32'(rob_out[1].valid), 32'h0);
                    compare("rob_out[1].robn", 32'(rob_out[1].robn), 32'h0);
                end
                // slots still waiting for a lane hold off their FU
                exp_ready = '1;
                for (int k = idx + 2; k < count; k++) begin
                    exp_ready[order_slot(k)] = 1'b0;
                end
                compare("fu_ready", 32'(fu_ready), 32'(exp_ready));
                idx += 2;
                @(negedge clock);
            end
        end
        repeat (2) @(negedge clock);
        compare("query_ready", 32'(query_ready), 32'(case_words[21][1:0]));
        if (case_errors == 0) begin
            $display("case %0d PASS", case_words[0]);
            pass_count++;
        end else begin
            $display("case %0d FAIL with %0d errors", case_words[0], case_errors);
        end
        error_count += case_errors;
        cases_checked++;
    endtask

    initial begin
        cases_checked = 0;
        error_count = 0;
        pass_count = 0;
        forever begin
            @(negedge clock);
            if (case_go) begin
                check_case();
            end
        end
    end

    always @(posedge all_done) begin
        $display("cases passed %0d, failed %0d, errors %0d",
                 pass_count, cases_checked - pass_count, error_count);
    end

endmodule

/* verification/tb_writeback_stage.sv */
`include "writeback_macros.svh"
`timescale 1ns/1ps

module tb_writeback_stage
    import writeback_pkg::*;
();

    localparam int NUM_CASES  = 7;
    localparam int CASE_WORDS = 22;
    localparam int TIMEOUT    = 60;

    logic                           clock;
    logic                           reset;
    logic [`NUM_FU-1:0]             fu_valid;
    logic [`NUM_FU-1:0]             fu_ready;
    fu_result_t [`NUM_FU-1:0]       fu_result;
    cdb_packet_t [`CDB_WIDTH-1:0]   cdb_out;
    rob_complete_t [`CDB_WIDTH-1:0] rob_out;
    prn_alloc_t [`CDB_WIDTH-1:0]    alloc;
    logic [1:0][`PRN_WIDTH-1:0]     query_prn;
    logic [1:0]                     query_ready;

    logic [31:0]                    case_mem [0:NUM_CASES*CASE_WORDS-1];
    logic [CASE_WORDS-1:0][31:0]    case_words;
    logic                           case_go;
    logic                           all_done;
    logic                           timed_out;
    int                             cases_checked;
    int                             error_count;

    writeback_stage dut0 (.*);

    writeback_checker checker0 (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // drives one case followed by blocked offers and a delayed alloc
    task automatic run_case(input int c);
        int base;
        int spoof_slot;
        int spoof_cycles;
        int alloc_delay;
        base = c * CASE_WORDS;
        spoof_slot = int'(case_mem[base+16][7:4]);
        spoof_cycles = case_mem[base+16][8] ? int'(case_mem[base+16][3:0]) : 0;
        alloc_delay = int'(case_mem[base+17][11:8]);
        @(posedge clock);
        for (int k = 0; k < CASE_WORDS; k++) begin
            case_words[k] <= case_mem[base+k];
        end
        case_go <= 1'b1;
        query_prn[0] <= case_mem[base+20][13:8];
        query_prn[1] <= case_mem[base+20][5:0];
        for (int s = 0; s < `NUM_FU; s++) begin
            fu_valid[s] <= case_mem[base+1][s];
            fu_result[s] <= '{robn: case_mem[base+2+s][12:8],
                              dest_prn: case_mem[base+2+s][5:0],
                              value: case_mem[base+9+s]};
        end
        if (alloc_delay == 0) begin
            alloc[0] <= '{valid: case_mem[base+17][12], prn: case_mem[base+17][5:0]};
        end
        for (int n = 1; n <= 4; n++) begin
            @(posedge clock);
            case_go <= 1'b0;
            fu_valid <= '0;
            alloc <= '0;
            if (n <= spoof_cycles) begin
                fu_valid[spoof_slot] <= 1'b1;
                fu_result[spoof_slot].value <= ~case_mem[base+9+spoof_slot];
            end
            if (alloc_delay == n) begin
                alloc[0] <= '{valid: case_mem[base+17][12], prn: case_mem[base+17][5:0]};
            end
        end
    endtask

    initial begin
        int t;
        $readmemh("verification/writeback_cases.txt", case_mem);
        reset = 1'b1;
        fu_valid = '0;
        fu_result = '0;
        alloc = '0;
        query_prn = '0;
        case_words = '0;
        case_go = 1'b0;
        all_done = 1'b0;
        timed_out = 1'b0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        for (int c = 0; c < NUM_CASES; c++) begin
            if (!timed_out) begin
                run_case(c);
                t = 0;
                while (cases_checked < c + 1 && t < TIMEOUT) begin
                    @(posedge clock);
                    t++;
                end
                if (cases_checked < c + 1) begin
                    $display("case %0d was not checked within %0d cycles", c, TIMEOUT);
                    timed_out = 1'b1;
                end
            end
        end
        all_done <= 1'b1;
        repeat (2) @(posedge clock);
        if (timed_out || error_count != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

/* writeback_stage.f */
+incdir+verilog
verilog/writeback_pkg.sv
verilog/psel_gen.sv
verilog/cdb_lane_mux.sv
verilog/cdb.sv
verilog/prf_ready_table.sv
verilog/writeback_stage.sv
verification/writeback_assertions.sv
verification/writeback_checker.sv
verification/tb_writeback_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_writeback_stage
FILELIST ?= writeback_stage.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* verification/writeback_cases.txt */
// id mask tag0..tag6 ({robn,prn} as rob<<8|prn) value0..value6 spoof({on,slot,cycles})
// alloc({valid,delay,prn}) order(slot nibbles) count query({prn0,prn1}) expected_query_ready
0 00 0 0 0 0 0 0 0  0 0 0 0 0 0 0  000 0000 0 0 003f 3
1 08 0 0 0 0105 0 0 0  0 0 0 1234abcd 0 0 0  000 0000 3 1 0005 3
2 7f 0210 0311 0412 0513 0614 0715 0816  a0000000 a0000001 a0000002 a0000003 a0000004 a0000005 a0000006  163 0000 0123456 7 1016 3
3 00 0 0 0 0 0 0 0  0 0 0 0 0 0 0  000 1020 0 0 2021 2
4 20 0 0 0 0 0 0920 0  0 0 0 0 0 55aa55aa 0  000 0000 5 1 2000 3
5 01 0a21 0 0 0 0 0 0  0badf00d 0 0 0 0 0 0  000 1121 0 1 2121 3
6 5a 0 0b01 0 0c03 0d04 0 0e06  0 c1c1c1c1 0 c3c3c3c3 c4c4c4c4 0 c6c6c6c6  000 0000 1346 4 0102 3
